// File: sources.f
verilog/lsu_pkg.sv
verilog/lsu_ctrl.sv
verilog/lsu_response_filter.sv
verilog/data_mem.sv
verilog/lsu_top.sv
tb/lsu_assertions.sv
tb/tb_lsu_top.sv

// File: tb/lsu_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_assertions #(
  parameter int DEPTH = 2
) (
  input logic clk,
  input logic rst_n,
  input logic bus_valid_i,
  input logic bus_ready_i,
  input logic bufferable_i,
  input logic bus_rvalid_i,
  input logic rvalid_i
);

  // One slot above DEPTH so an overflow stays visible
  localparam int CNT_W = $clog2(DEPTH + 2);

  // Count of failed assertions
  int assert_errors = 0;

  // Bus transfers still owing a response, seen only at the ports
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  // Bufferable flag per outstanding transfer, bit 0 is the oldest
  logic [DEPTH:0]   buf_q;
  logic [DEPTH:0]   buf_d;
  logic             oldest_buf;

  always_comb begin
    cnt_d = cnt_q;
    buf_d = buf_q;
    // Oldest leaves on its response
    if (bus_rvalid_i && (cnt_q != '0)) begin
      buf_d = buf_q >> 1;
      cnt_d = cnt_q - 1'b1;
    end
    // Newest enters behind the rest
    if (bus_valid_i && bus_ready_i) begin
      if (cnt_d <= CNT_W'(DEPTH)) begin
        buf_d[cnt_d] = bufferable_i;
      end
      cnt_d = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      buf_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      buf_q <= buf_d;
    end
  end

  // Empty bus side counts as non-bufferable
  assign oldest_buf = (cnt_q != '0) && buf_q[0];

  // Bus side never tracks more than DEPTH transfers
  cnt_bound: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= CNT_W'(DEPTH))
    else begin
      assert_errors++;
      $error("bus-side count %0d above DEPTH", cnt_q);
    end

  // Full filter holds requests off the bus
  full_gate: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == CNT_W'(DEPTH)) |-> !bus_valid_i)
    else begin
      assert_errors++;
      $error("bus_valid_o high with DEPTH transfers outstanding");
    end

  // Non-bufferable oldest transfer passes the bus strobe through
  pass_through: assert property (@(posedge clk) disable iff (!rst_n)
    !oldest_buf |-> (rvalid_i == bus_rvalid_i))
    else begin
      assert_errors++;
      $error("rvalid_o differs from bus_rvalid_i for a non-bufferable transfer");
    end

endmodule

bind lsu_response_filter lsu_assertions #(
  .DEPTH (DEPTH)
) i_lsu_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .bus_valid_i  (bus_valid_o),
  .bus_ready_i  (bus_ready_i),
  .bufferable_i (bufferable_i),
  .bus_rvalid_i (bus_rvalid_i),
  .rvalid_i     (rvalid_o)
);

`default_nettype wire

// File: tb/tb_lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int DEPTH     = 2;
  localparam int LATENCY   = 3;
  localparam int MEM_WORDS = 64;
  // Longest any single wait may run, in cycles
  localparam int TIMEOUT   = 200;

  logic              clk;
  logic              rst_n;
  logic              stall_i;
  logic              cmd_valid_i;
  lsu_op_e           cmd_op_i;
  logic [ADDR_W-1:0] cmd_addr_i;
  logic [DATA_W-1:0] cmd_wdata_i;
  logic              cmd_bufferable_i;
  logic              cmd_ready_o;
  logic              res_valid_o;
  logic [DATA_W-1:0] res_rdata_o;
  lsu_err_e          res_err_o;
  logic [1:0]        bus_err_o;
  logic              busy_o;

  // Reference memory by word index, missing words read as zero
  logic [DATA_W-1:0] ref_mem [int];
  // Expected results in command order
  logic [DATA_W-1:0] exp_data_q [$];
  lsu_err_e          exp_err_q  [$];
  // Bufferable stores out of range still owing a late error pulse
  int                late_err_pending;
  logic [31:0]       lfsr_state;

  lsu_top #(
    .DEPTH     (DEPTH),
    .LATENCY   (LATENCY),
    .MEM_WORDS (MEM_WORDS)
  ) i_lsu_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_i          (stall_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_op_i         (cmd_op_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_wdata_i      (cmd_wdata_i),
    .cmd_bufferable_i (cmd_bufferable_i),
    .cmd_ready_o      (cmd_ready_o),
    .res_valid_o      (res_valid_o),
    .res_rdata_o      (res_rdata_o),
    .res_err_o        (res_err_o),
    .bus_err_o        (bus_err_o),
    .busy_o           (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                            input string name);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_err(input lsu_err_e actual, input lsu_err_e expected, input string name);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %s, expected %s", $time, name,
               actual.name(), expected.name());
      stop_run();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value[i]   = lfsr_state[0];
    end
    return value;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Called at the accepting edge
  task automatic model_accept(input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic buf_en);
    int   idx;
    logic in_range;
    idx      = int'(addr >> 2);
    in_range = addr < ADDR_W'(MEM_WORDS * 4);
    if (addr[1:0] != 2'b00) begin
      // Never reaches the bus, memory untouched
      exp_data_q.push_back('0);
      exp_err_q.push_back(ERR_MISALIGNED);
    end else if (op == LOAD) begin
      if (!in_range) begin
        exp_data_q.push_back('0);
        exp_err_q.push_back(ERR_BUS_LOAD);
      end else if (ref_mem.exists(idx)) begin
        exp_data_q.push_back(ref_mem[idx]);
        exp_err_q.push_back(ERR_NONE);
      end else begin
        exp_data_q.push_back('0);
        exp_err_q.push_back(ERR_NONE);
      end
    end else begin
      exp_data_q.push_back('0);
      if (in_range) begin
        ref_mem[idx] = data;
        exp_err_q.push_back(ERR_NONE);
      end else if (buf_en) begin
        // Early completion, error follows on bus_err_o
        exp_err_q.push_back(ERR_NONE);
        late_err_pending++;
      end else begin
        exp_err_q.push_back(ERR_BUS_STORE);
      end
    end
  endtask

  // Result and late error monitor, mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (res_valid_o) begin
        if (exp_err_q.size() == 0) begin
          $display("Result at %0t ns with no command pending", $time);
          stop_run();
        end else begin
          check_data(res_rdata_o, exp_data_q.pop_front(), "res_rdata_o");
          check_err(res_err_o, exp_err_q.pop_front(), "res_err_o");
        end
      end
      if (bus_err_o[0]) begin
        if (late_err_pending == 0) begin
          $display("Late bus error at %0t ns with no bufferable store owing one", $time);
          stop_run();
        end else begin
          check_flag(bus_err_o[1], 1'b1, "bus_err_o[1]");
          late_err_pending--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Present one command until taken, stall held for stall_cycles
  task automatic issue(input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input logic buf_en,
                       input int stall_cycles);
    int   cycles;
    logic accepted;
    cycles   = 0;
    accepted = 1'b0;
    if (stall_cycles > 0) begin
      stall_i = 1'b1;
    end
    cmd_valid_i      = 1'b1;
    cmd_op_i         = op;
    cmd_addr_i       = addr;
    cmd_wdata_i      = data;
    cmd_bufferable_i = buf_en;
    while (!accepted) begin
      @(negedge clk);
      // Aligned commands need the memory
      if (stall_i && (addr[1:0] == 2'b00)) begin
        check_flag(cmd_ready_o, 1'b0, "cmd_ready_o");
      end
      accepted = cmd_ready_o;
      @(posedge clk);
      if (!accepted) begin
        #2;
        cycles++;
        if (cycles == stall_cycles) begin
          stall_i = 1'b0;
        end
        if (cycles > stall_cycles + TIMEOUT) begin
          $display("Timeout at %0t ns: command at %h never accepted", $time, addr);
          stop_run();
        end
      end
    end
    model_accept(op, addr, data, buf_en);
    #2;
    cmd_valid_i = 1'b0;
    stall_i     = 1'b0;
  endtask

  // All results in, late errors seen, DUT drained
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((exp_err_q.size() != 0) || (late_err_pending != 0) || busy_o) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout at %0t ns: %0d results and %0d late bus errors missing, busy_o %b",
                 $time, exp_err_q.size(), late_err_pending, busy_o);
        stop_run();
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic check_reset_state();
    @(negedge clk);
    check_flag(cmd_ready_o, 1'b1, "cmd_ready_o");
    check_flag(res_valid_o, 1'b0, "res_valid_o");
    check_flag(bus_err_o[0], 1'b0, "bus_err_o[0]");
    check_flag(bus_err_o[1], 1'b0, "bus_err_o[1]");
    @(posedge clk);
    #2;
  endtask

  task automatic test_store_load();
    for (int i = 0; i < 4; i++) begin
      issue(STORE, ADDR_W'(32 + i * 4), 32'hA5A5_0000 + DATA_W'(i), 1'b0, 0);
    end
    for (int i = 0; i < 4; i++) begin
      issue(LOAD, ADDR_W'(32 + i * 4), '0, 1'b0, 0);
    end
    wait_idle();
  endtask

  task automatic test_bufferable();
    issue(STORE, 32'h40, 32'hCAFE_0001, 1'b1, 0);
    issue(LOAD, 32'h40, '0, 1'b0, 0);
    // Back to back bufferable stores
    issue(STORE, 32'h44, 32'hCAFE_0002, 1'b1, 0);
    issue(STORE, 32'h48, 32'hCAFE_0003, 1'b1, 0);
    issue(STORE, 32'h4C, 32'hCAFE_0004, 1'b1, 0);
    // Bufferable flag on a load is dropped
    issue(LOAD, 32'h48, '0, 1'b1, 0);
    issue(LOAD, 32'h4C, '0, 1'b0, 0);
    wait_idle();
  endtask

  task automatic test_stall();
    issue(STORE, 32'h80, 32'h5151_0080, 1'b0, 8);
    issue(LOAD, 32'h80, '0, 1'b0, 0);
    issue(STORE, 32'h84, 32'h5151_0084, 1'b1, 3);
    issue(LOAD, 32'h84, '0, 1'b0, 5);
    issue(LOAD, 32'h80, '0, 1'b0, 2);
    wait_idle();
  endtask

  task automatic test_bus_error();
    issue(LOAD, 32'h100, '0, 1'b0, 0);
    issue(STORE, 32'h104, 32'hBAD0_0104, 1'b0, 0);
    issue(STORE, 32'h108, 32'hBAD0_0108, 1'b1, 0);
    // In-range traffic behind the failing store
    issue(STORE, 32'h0C, 32'h600D_000C, 1'b1, 0);
    issue(LOAD, 32'h0C, '0, 1'b0, 0);
    issue(STORE, 32'h400, 32'hBAD0_0400, 1'b1, 0);
    issue(LOAD, 32'h400, '0, 1'b1, 0);
    wait_idle();
  endtask

  task automatic test_misaligned();
    issue(STORE, 32'h20, 32'h1234_5678, 1'b0, 0);
    issue(STORE, 32'h21, 32'hDEAD_BEEF, 1'b0, 0);
    issue(LOAD, 32'h20, '0, 1'b0, 0);
    issue(LOAD, 32'h22, '0, 1'b0, 0);
    issue(STORE, 32'h23, 32'hDEAD_0023, 1'b1, 0);
    issue(LOAD, 32'h20, '0, 1'b0, 0);
    wait_idle();
  endtask

  task automatic test_random();
    lsu_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              buf_en;
    int                stall_cycles;
    for (int n = 0; n < 200; n++) begin
      op           = (rand_bits(1) != 0) ? STORE : LOAD;
      // First 16 words so loads often hit earlier stores
      addr         = rand_bits(4) << 2;
      data         = rand_bits(32);
      buf_en       = rand_bits(1) != 0;
      stall_cycles = 0;
      if (rand_bits(3) == 0) begin
        stall_cycles = 1 + int'(rand_bits(2));
      end
      issue(op, addr, data, buf_en, stall_cycles);
    end
    // Drained means busy_o low within the timeout
    wait_idle();
  endtask

  initial begin
    late_err_pending = 0;
    lfsr_state       = 32'h908e2c7e;
    rst_n            = 1'b0;
    stall_i          = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_op_i         = LOAD;
    cmd_addr_i       = '0;
    cmd_wdata_i      = '0;
    cmd_bufferable_i = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_reset_state();
    test_store_load();
    test_bufferable();
    test_stall();
    test_bus_error();
    test_misaligned();
    test_random();

    if (i_lsu_top.i_lsu_response_filter.i_lsu_assertions.assert_errors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Assertion failures: %0d",
               i_lsu_top.i_lsu_response_filter.i_lsu_assertions.assert_errors);
      $display("test failed");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
  parameter int LATENCY   = 3,
  parameter int MEM_WORDS = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall_i,
  // Request
  input  logic                        valid_i,
  input  lsu_pkg::lsu_op_e            op_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]  wdata_i,
  output logic                        ready_o,
  // Response strobe, LATENCY cycles after acceptance
  output logic                        rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0]  rdata_o,
  output logic                        err_o
);

  import lsu_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // Word storage
  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // Response pipeline, stage LATENCY-1 is the output
  logic [LATENCY-1:0] valid_pipe_q;
  logic [LATENCY-1:0] err_pipe_q;
  logic [DATA_W-1:0]  data_pipe_q [LATENCY];

  logic              accept;
  logic              in_range;
  logic [IDX_W-1:0]  idx;
  logic [DATA_W-1:0] rd_word;

  ////////////////////////////////////////
  // Access at acceptance
  ////////////////////////////////////////

  // Stall only blocks new requests, the pipeline keeps moving
  assign ready_o  = !stall_i;
  assign accept   = valid_i && ready_o;

  assign in_range = addr_i < ADDR_W'(MEM_WORDS * 4);
  assign idx      = addr_i[IDX_W+1:2];

  // Zero data for stores and out-of-range accesses
  assign rd_word = (accept && in_range && (op_i == LOAD)) ? mem_q[idx] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept && in_range && (op_i == STORE)) begin
      mem_q[idx] <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Fixed latency pipeline
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe_q <= '0;
      err_pipe_q   <= '0;
    end else begin
      for (int i = LATENCY - 1; i > 0; i--) begin
        valid_pipe_q[i] <= valid_pipe_q[i-1];
        err_pipe_q[i]   <= err_pipe_q[i-1];
      end
      valid_pipe_q[0] <= accept;
      // Out of range access reports an error
      err_pipe_q[0]   <= accept && !in_range;
    end
  end

  // Read data, no reset needed on the payload
  always_ff @(posedge clk) begin
    for (int i = LATENCY - 1; i > 0; i--) begin
      data_pipe_q[i] <= data_pipe_q[i-1];
    end
    data_pipe_q[0] <= rd_word;
  end

  assign rvalid_o = valid_pipe_q[LATENCY-1];
  assign err_o    = err_pipe_q[LATENCY-1];
  assign rdata_o  = data_pipe_q[LATENCY-1];

endmodule

`default_nettype wire

// File: verilog/lsu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl #(
  parameter int DEPTH = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // Command side
  input  logic                        cmd_valid_i,
  input  lsu_pkg::lsu_op_e            cmd_op_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  cmd_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]  cmd_wdata_i,
  input  logic                        cmd_bufferable_i,
  output logic                        cmd_ready_o,
  // Transfer request towards the filter
  output logic                        req_valid_o,
  output lsu_pkg::lsu_op_e            req_op_o,
  output logic [lsu_pkg::ADDR_W-1:0]  req_addr_o,
  output logic [lsu_pkg::DATA_W-1:0]  req_wdata_o,
  output logic                        req_bufferable_o,
  input  logic                        req_ready_i,
  // Filtered response, rsp_err_i is {store type, error flag}
  input  logic                        rsp_valid_i,
  input  logic [lsu_pkg::DATA_W-1:0]  rsp_rdata_i,
  input  logic [1:0]                  rsp_err_i,
  // Result, one per command in order
  output logic                        res_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]  res_rdata_o,
  output lsu_pkg::lsu_err_e           res_err_o
);

  import lsu_pkg::*;

  // One tag more than the filter can keep outstanding
  localparam int QD    = DEPTH + 1;
  localparam int PTR_W = $clog2(QD);
  localparam int CNT_W = $clog2(QD + 1);

  // Tag queue, no reset on payload
  logic             tag_mis_q  [QD];
  logic             tag_load_q [QD];
  logic             tag_buf_q  [QD];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  // Misaligned tags still waiting in the queue
  logic [CNT_W-1:0] mis_cnt_q;

  logic misaligned;
  logic queue_full;
  logic cmd_accept;
  logic head_valid;
  logic retire;
  logic bus_err_hit;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QD - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Command acceptance
  ////////////////////////////////////////

  assign misaligned = cmd_addr_i[1:0] != 2'b00;
  assign queue_full = cnt_q == CNT_W'(QD);

  // Aligned commands wait while a misaligned tag is queued
  // so no response can arrive while it sits at the head
  assign req_valid_o      = cmd_valid_i && !misaligned && !queue_full && (mis_cnt_q == '0);
  assign req_op_o         = cmd_op_i;
  assign req_addr_o       = cmd_addr_i;
  assign req_wdata_o      = cmd_wdata_i;
  // Only stores may be bufferable
  assign req_bufferable_o = cmd_bufferable_i && (cmd_op_i == STORE);

  // Misaligned taken at once, no bus transfer
  assign cmd_ready_o = !queue_full && (misaligned || (req_ready_i && (mis_cnt_q == '0)));
  assign cmd_accept  = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      tag_mis_q[wr_ptr_q]  <= misaligned;
      tag_load_q[wr_ptr_q] <= cmd_op_i == LOAD;
      tag_buf_q[wr_ptr_q]  <= req_bufferable_o;
    end
  end

  ////////////////////////////////////////
  // Retirement
  ////////////////////////////////////////

  assign head_valid = cnt_q != '0;
  // Misaligned head retires without waiting for the bus
  assign retire     = head_valid && (tag_mis_q[rd_ptr_q] || rsp_valid_i);

  // Bus errors count only for non-bufferable heads
  assign bus_err_hit = !tag_buf_q[rd_ptr_q] && rsp_err_i[0];

  assign res_valid_o = retire;
  assign res_rdata_o = (retire && tag_load_q[rd_ptr_q] && !tag_mis_q[rd_ptr_q]) ?
                       rsp_rdata_i : '0;

  always_comb begin
    res_err_o = ERR_NONE;
    if (retire) begin
      if (tag_mis_q[rd_ptr_q]) begin
        res_err_o = ERR_MISALIGNED;
      end else if (bus_err_hit) begin
        // Store type comes from the oldest bus-side entry
        if (rsp_err_i[1]) begin
          res_err_o = ERR_BUS_STORE;
        end else begin
          res_err_o = ERR_BUS_LOAD;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      cnt_q     <= '0;
      mis_cnt_q <= '0;
    end else begin
      if (cmd_accept) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (retire) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q     <= cnt_q + CNT_W'(cmd_accept) - CNT_W'(retire);
      mis_cnt_q <= mis_cnt_q + CNT_W'(cmd_accept && misaligned)
                   - CNT_W'(retire && tag_mis_q[rd_ptr_q]);
    end
  end

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Byte address, word aligned for every bus transfer
  localparam int ADDR_W = 32;

  // One data word
  localparam int DATA_W = 32;

  ////////////////////////////////////////
  // Operation and result types
  ////////////////////////////////////////

  // Single word access kind
  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } lsu_op_e;

  // Result error kind, one per retired command
  // Bus errors of bufferable stores never show up here
  typedef enum logic [1:0] {
    ERR_NONE       = 2'd0,
    ERR_MISALIGNED = 2'd1,
    ERR_BUS_LOAD   = 2'd2,
    ERR_BUS_STORE  = 2'd3
  } lsu_err_e;

endpackage

`default_nettype wire

// File: verilog/lsu_response_filter.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_response_filter #(
  parameter int DEPTH = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // Core side request
  input  logic                        valid_i,
  input  lsu_pkg::lsu_op_e            op_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]  wdata_i,
  input  logic                        bufferable_i,
  output logic                        ready_o,
  // Bus side request
  output logic                        bus_valid_o,
  output lsu_pkg::lsu_op_e            bus_op_o,
  output logic [lsu_pkg::ADDR_W-1:0]  bus_addr_o,
  output logic [lsu_pkg::DATA_W-1:0]  bus_wdata_o,
  input  logic                        bus_ready_i,
  // Bus response
  input  logic                        bus_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                        bus_err_i,
  // Filtered response
  output logic                        rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0]  rdata_o,
  output logic [1:0]                  err_o,
  output logic                        busy_o,
  output logic                        bus_busy_o
);

  import lsu_pkg::*;

  localparam int CNT_W = $clog2(DEPTH + 1);

  // Flags kept per outstanding transfer
  typedef struct packed {
    logic bufferable;
    logic store;
  } outstanding_t;

  // Entry 1 is the newest, entry N is the oldest of N outstanding
  // Entry 0 stays zero so an empty count reads as non-bufferable
  outstanding_t [DEPTH:0] outstanding_q;
  outstanding_t [DEPTH:0] outstanding_d;

  // Outstanding transfers seen from the bus and from the core
  logic [CNT_W-1:0] bus_cnt_q;
  logic [CNT_W-1:0] core_cnt_q;

  logic has_room;
  logic core_accept;
  logic bus_accept;
  logic bus_oldest_buf;
  logic core_oldest_buf;

  ////////////////////////////////////////
  // Request path
  ////////////////////////////////////////

  // Stop at DEPTH so the bus count cannot overflow
  assign has_room    = bus_cnt_q < CNT_W'(DEPTH);
  assign ready_o     = bus_ready_i && has_room;
  assign bus_valid_o = valid_i && has_room;

  assign bus_op_o    = op_i;
  assign bus_addr_o  = addr_i;
  assign bus_wdata_o = wdata_i;

  // Both sides accept in the same cycle, gated alike
  assign core_accept = valid_i && ready_o;
  assign bus_accept  = bus_valid_o && bus_ready_i;

  assign busy_o     = (bus_cnt_q != '0) || valid_i;
  assign bus_busy_o = bus_cnt_q != '0;

  ////////////////////////////////////////
  // Outstanding flags
  ////////////////////////////////////////

  always_comb begin
    outstanding_d = outstanding_q;
    if (bus_accept) begin
      // Shift towards the oldest end, newest enters at 1
      outstanding_d[DEPTH:1]       = outstanding_q[DEPTH-1:0];
      outstanding_d[1].bufferable  = bufferable_i;
      outstanding_d[1].store       = op_i == STORE;
      outstanding_d[0]             = '0;
    end
  end

  assign bus_oldest_buf  = outstanding_q[bus_cnt_q].bufferable;
  assign core_oldest_buf = outstanding_q[core_cnt_q].bufferable;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      bus_cnt_q     <= '0;
      core_cnt_q    <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      bus_cnt_q     <= bus_cnt_q + CNT_W'(bus_accept) - CNT_W'(bus_rvalid_i);
      core_cnt_q    <= core_cnt_q + CNT_W'(core_accept) - CNT_W'(rvalid_o);
    end
  end

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  // Bufferable oldest on the bus lets the core side run ahead
  // as long as its own oldest is bufferable too
  // otherwise the bus strobe passes straight through
  assign rvalid_o = bus_oldest_buf ? core_oldest_buf : bus_rvalid_i;
  assign rdata_o  = bus_rdata_i;

  // Bit 0 flags a late error of a bufferable store
  // Bit 1 is the store type of the oldest bus-side transfer
  assign err_o[0] = bus_rvalid_i && bus_err_i && bus_oldest_buf;
  assign err_o[1] = outstanding_q[bus_cnt_q].store;

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
  parameter int DEPTH     = 2,
  parameter int LATENCY   = 3,
  parameter int MEM_WORDS = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall_i,
  // Command
  input  logic                        cmd_valid_i,
  input  lsu_pkg::lsu_op_e            cmd_op_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  cmd_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]  cmd_wdata_i,
  input  logic                        cmd_bufferable_i,
  output logic                        cmd_ready_o,
  // Result
  output logic                        res_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]  res_rdata_o,
  output lsu_pkg::lsu_err_e           res_err_o,
  // Late bufferable store error, {store, flag}
  output logic [1:0]                  bus_err_o,
  output logic                        busy_o
);

  import lsu_pkg::*;

  // Controller to filter
  logic              req_valid;
  lsu_op_e           req_op;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic              req_bufferable;
  logic              req_ready;

  // Filter to memory
  logic              bus_valid;
  lsu_op_e           bus_op;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_wdata;
  logic              bus_ready;
  logic              bus_rvalid;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_err;

  // Filter back to controller
  logic              filt_rvalid;
  logic [DATA_W-1:0] filt_rdata;
  logic [1:0]        filt_err;

  assign bus_err_o = filt_err;

  lsu_ctrl #(
    .DEPTH (DEPTH)
  ) i_lsu_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_op_i         (cmd_op_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_wdata_i      (cmd_wdata_i),
    .cmd_bufferable_i (cmd_bufferable_i),
    .cmd_ready_o      (cmd_ready_o),
    .req_valid_o      (req_valid),
    .req_op_o         (req_op),
    .req_addr_o       (req_addr),
    .req_wdata_o      (req_wdata),
    .req_bufferable_o (req_bufferable),
    .req_ready_i      (req_ready),
    .rsp_valid_i      (filt_rvalid),
    .rsp_rdata_i      (filt_rdata),
    // Raw bus error flag with the filter's store type
    .rsp_err_i        ({filt_err[1], bus_err}),
    .res_valid_o      (res_valid_o),
    .res_rdata_o      (res_rdata_o),
    .res_err_o        (res_err_o)
  );

  lsu_response_filter #(
    .DEPTH (DEPTH)
  ) i_lsu_response_filter (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (req_valid),
    .op_i         (req_op),
    .addr_i       (req_addr),
    .wdata_i      (req_wdata),
    .bufferable_i (req_bufferable),
    .ready_o      (req_ready),
    .bus_valid_o  (bus_valid),
    .bus_op_o     (bus_op),
    .bus_addr_o   (bus_addr),
    .bus_wdata_o  (bus_wdata),
    .bus_ready_i  (bus_ready),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .bus_err_i    (bus_err),
    .rvalid_o     (filt_rvalid),
    .rdata_o      (filt_rdata),
    .err_o        (filt_err),
    .busy_o       (busy_o),
    // Bus-only busy has no user at this level
    .bus_busy_o   ()
  );

  data_mem #(
    .LATENCY   (LATENCY),
    .MEM_WORDS (MEM_WORDS)
  ) i_data_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_i  (stall_i),
    .valid_i  (bus_valid),
    .op_i     (bus_op),
    .addr_i   (bus_addr),
    .wdata_i  (bus_wdata),
    .ready_o  (bus_ready),
    .rvalid_o (bus_rvalid),
    .rdata_o  (bus_rdata),
    .err_o    (bus_err)
  );

endmodule

`default_nettype wire
